/* rtl/icache_pkg.sv */
package icache_pkg;

    // bus widths
    localparam int ADDR_W  = 32;
    localparam int FETCH_W = 64;   // one doubleword per fetch

    // exception codes
    localparam int EXC_W = 7;
    localparam logic [EXC_W-1:0] EXC_NONE = 7'h00;
    localparam logic [EXC_W-1:0] EXC_ADEF = 7'h08;   // fetch address not word aligned

    // cache operations
    localparam int CACOP_W = 2;
    localparam logic [CACOP_W-1:0] CACOP_INDEX_INV = 2'b01;
    localparam logic [CACOP_W-1:0] CACOP_HIT_INV   = 2'b10;

    // main FSM
    localparam int ST_W = 3;
    localparam logic [ST_W-1:0] ST_IDLE   = 3'd0;
    localparam logic [ST_W-1:0] ST_LOOKUP = 3'd1;   // arrays valid, hit known
    localparam logic [ST_W-1:0] ST_MISS   = 3'd2;   // waiting on memory
    localparam logic [ST_W-1:0] ST_REFILL = 3'd3;   // answer from return buffer
    localparam logic [ST_W-1:0] ST_CACOP  = 3'd4;

endpackage

/* rtl/icache_req_decode.sv */
`timescale 1ns/1ps

module icache_req_decode #(
    parameter int INDEX_W = 6,
    parameter int OFFS_W  = 2,
    localparam int TAG_W  = icache_pkg::ADDR_W - INDEX_W - OFFS_W - 2
) (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              i_capture,
    input  logic [icache_pkg::ADDR_W-1:0]     i_req_addr,
    input  logic                              i_uncached,
    input  logic                              i_cacop_en,
    input  logic [icache_pkg::CACOP_W-1:0]    i_cacop_code,
    output logic [INDEX_W-1:0]                o_index,
    output logic [TAG_W-1:0]                  o_tag,
    output logic [OFFS_W-2:0]                 o_dw_sel,
    output logic                              o_way_bit,
    output logic                              o_uncached,
    output logic                              o_index_inv,
    output logic                              o_hit_inv,
    output logic [icache_pkg::EXC_W-1:0]      o_exc,
    output logic [icache_pkg::ADDR_W-1:0]     o_pc,
    output logic [icache_pkg::ADDR_W-1:0]     o_mem_addr,
    output logic                              o_mem_uncached
);

    localparam int BOFF_W = OFFS_W + 2;

    // one address word, seen as a fetch or as a maintenance target
    typedef union packed {
        struct packed {
            logic [TAG_W-1:0]   tag;
            logic [INDEX_W-1:0] index;
            logic [OFFS_W-2:0]  dw;        // doubleword within the line
            logic [2:0]         byte_sel;
        } fetch;
        struct packed {
            logic [TAG_W-1:0]   line_tag;
            logic [INDEX_W-1:0] index;
            logic [BOFF_W-2:0]  offs;
            logic               way;       // index invalidate target way
        } maint;
    } fetch_addr_u;

    fetch_addr_u                       req_q;
    logic                              uncached_q;
    logic                              cacop_q;
    logic [icache_pkg::CACOP_W-1:0]    code_q;

    always_ff @(posedge clk) begin
        if (i_capture) begin
            req_q <= i_req_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            uncached_q <= 1'b0;
            cacop_q    <= 1'b0;
            code_q     <= '0;
        end else if (i_capture) begin
            uncached_q <= i_uncached;
            cacop_q    <= i_cacop_en;
            code_q     <= i_cacop_code;
        end
    end

    assign o_index    = req_q.fetch.index;
    assign o_tag      = req_q.fetch.tag;
    assign o_dw_sel   = req_q.fetch.dw;
    assign o_way_bit  = req_q.maint.way;
    assign o_uncached = uncached_q;
    assign o_pc       = req_q;

    assign o_index_inv = cacop_q && (code_q == icache_pkg::CACOP_INDEX_INV);
    assign o_hit_inv   = cacop_q && (code_q == icache_pkg::CACOP_HIT_INV);

    // maintenance addresses may carry the way number in bit 0
    assign o_exc = (!cacop_q && (req_q.fetch.byte_sel[1:0] != 2'b00)) ?
                   icache_pkg::EXC_ADEF : icache_pkg::EXC_NONE;

    assign o_mem_addr = uncached_q ? {req_q[icache_pkg::ADDR_W-1:3], 3'b000}
                                   : {req_q.fetch.tag, req_q.fetch.index, {BOFF_W{1'b0}}};
    assign o_mem_uncached = uncached_q;

endmodule

/* rtl/icache_ctrl.sv */
`timescale 1ns/1ps

module icache_ctrl (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              i_req_valid,
    input  logic                              i_cacop_en,
    output logic                              o_req_ready,
    output logic                              o_capture,
    input  logic                              i_hit,
    input  logic                              i_uncached,
    input  logic                              i_index_inv,
    input  logic                              i_hit_inv,
    input  logic [icache_pkg::EXC_W-1:0]      i_exc,
    output logic [icache_pkg::ST_W-1:0]       o_state,
    output logic                              o_mem_valid,
    input  logic                              i_mem_ready,
    output logic                              o_fill_we,
    output logic                              o_lru_we,
    output logic                              o_inv_we,
    output logic                              o_resp_valid,
    output logic                              o_cacop_done
);

    logic [icache_pkg::ST_W-1:0] state;
    logic [icache_pkg::ST_W-1:0] state_nx;
    logic [icache_pkg::ST_W-1:0] accept_st;   // where an accepted request goes
    logic                        in_lookup;
    logic                        lookup_exc;
    logic                        lookup_hit;
    logic                        accept;
    logic                        done_q;

    assign in_lookup  = (state == icache_pkg::ST_LOOKUP);
    assign lookup_exc = in_lookup && (i_exc != icache_pkg::EXC_NONE);
    assign lookup_hit = in_lookup && (i_exc == icache_pkg::EXC_NONE)
                        && !i_uncached && i_hit;   // uncached ignores the arrays

    // new request taken when idle or while answering in lookup
    assign o_req_ready = (state == icache_pkg::ST_IDLE) || lookup_exc || lookup_hit;
    assign accept      = o_req_ready && i_req_valid;
    assign o_capture   = accept;
    assign accept_st   = i_cacop_en ? icache_pkg::ST_CACOP : icache_pkg::ST_LOOKUP;

    always_comb begin
        state_nx = state;
        case (state)
            icache_pkg::ST_IDLE: begin
                if (accept) begin
                    state_nx = accept_st;
                end
            end
            icache_pkg::ST_LOOKUP: begin
                if (lookup_exc || lookup_hit) begin
                    state_nx = accept ? accept_st : icache_pkg::ST_IDLE;
                end else begin
                    state_nx = icache_pkg::ST_MISS;   // cached miss or uncached fetch
                end
            end
            icache_pkg::ST_MISS: begin
                if (i_mem_ready) begin
                    state_nx = icache_pkg::ST_REFILL;
                end
            end
            icache_pkg::ST_REFILL: begin
                state_nx = icache_pkg::ST_IDLE;
            end
            icache_pkg::ST_CACOP: begin
                state_nx = icache_pkg::ST_IDLE;
            end
            default: begin
                state_nx = icache_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= icache_pkg::ST_IDLE;
        end else begin
            state <= state_nx;
        end
    end

    // request held on the memory side until the line comes back
    assign o_mem_valid = (state == icache_pkg::ST_MISS);

    // line written on the data beat itself, the refill cycle answers from the buffer
    assign o_fill_we = o_mem_valid && i_mem_ready && !i_uncached;
    assign o_lru_we  = lookup_hit || o_fill_we;

    assign o_inv_we = (state == icache_pkg::ST_CACOP)
                      && (i_index_inv || (i_hit_inv && i_hit));

    assign o_resp_valid = lookup_hit || lookup_exc || (state == icache_pkg::ST_REFILL);

    // done one cycle after the invalidate lands
    always_ff @(posedge clk) begin
        if (!rstn) begin
            done_q <= 1'b0;
        end else begin
            done_q <= (state == icache_pkg::ST_CACOP);
        end
    end

    assign o_cacop_done = done_q;
    assign o_state      = state;

endmodule

/* rtl/icache_way_store.sv */
`timescale 1ns/1ps

module icache_way_store #(
    parameter int INDEX_W = 6,
    parameter int OFFS_W  = 2,
    localparam int TAG_W  = icache_pkg::ADDR_W - INDEX_W - OFFS_W - 2,
    localparam int LINE_W = 32 << OFFS_W
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [INDEX_W-1:0]    i_rd_index,   // read port, incoming request
    input  logic [INDEX_W-1:0]    i_index,      // write port, captured request
    input  logic [TAG_W-1:0]      i_tag,
    input  logic                  i_way_bit,
    input  logic                  i_index_inv,
    input  logic                  i_fill_we,
    input  logic                  i_lru_we,
    input  logic                  i_inv_we,
    input  logic [LINE_W-1:0]     i_fill_line,
    output logic                  o_hit,
    output logic                  o_hit_way,
    output logic [LINE_W-1:0]     o_line0,
    output logic [LINE_W-1:0]     o_line1
);

    localparam int SETS = 1 << INDEX_W;

    logic [SETS-1:0]    lru;        // 1 means way 1 is least recently used
    logic               victim;
    logic               used_way;
    logic               inv_way;
    logic [1:0]         hit_vec;
    logic [LINE_W-1:0]  line_rd [2];

    assign victim   = lru[i_index];
    assign inv_way  = i_index_inv ? i_way_bit : o_hit_way;
    assign used_way = i_fill_we ? victim : o_hit_way;

    for (genvar w = 0; w < 2; w++) begin : g_way
        logic [TAG_W-1:0]   tag_mem  [SETS];
        logic [LINE_W-1:0]  data_mem [SETS];
        logic [SETS-1:0]    valid;
        logic               valid_q;
        logic [TAG_W-1:0]   tag_q;
        logic               fill_sel;
        logic               inv_sel;

        assign fill_sel = i_fill_we && (victim == w);
        assign inv_sel  = i_inv_we && (inv_way == w);

        always_ff @(posedge clk) begin
            if (!rstn) begin
                valid   <= '0;
                valid_q <= 1'b0;
            end else begin
                if (fill_sel) begin
                    valid[i_index] <= 1'b1;
                end else if (inv_sel) begin
                    valid[i_index] <= 1'b0;
                end
                valid_q <= valid[i_rd_index];
            end
        end

        always_ff @(posedge clk) begin
            if (fill_sel) begin
                tag_mem[i_index]  <= i_tag;
                data_mem[i_index] <= i_fill_line;
            end
            tag_q      <= tag_mem[i_rd_index];
            line_rd[w] <= data_mem[i_rd_index];
        end

        assign hit_vec[w] = valid_q && (tag_q == i_tag);
    end

    // lru names the way not touched last
    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru <= '0;
        end else if (i_lru_we) begin
            lru[i_index] <= ~used_way;
        end
    end

    assign o_hit     = |hit_vec;
    assign o_hit_way = hit_vec[1];
    assign o_line0   = line_rd[0];
    assign o_line1   = line_rd[1];

endmodule

/* rtl/icache_fetch_result.sv */
`timescale 1ns/1ps

module icache_fetch_result #(
    parameter int OFFS_W  = 2,
    localparam int LINE_W = 32 << OFFS_W
) (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic [icache_pkg::ST_W-1:0]       i_state,
    input  logic                              i_mem_ready,
    input  logic [LINE_W-1:0]                 i_mem_rdata,
    input  logic [LINE_W-1:0]                 i_line0,
    input  logic [LINE_W-1:0]                 i_line1,
    input  logic                              i_hit_way,
    input  logic [OFFS_W-2:0]                 i_dw_sel,
    input  logic                              i_uncached,
    output logic [icache_pkg::FETCH_W-1:0]    o_resp_data
);

    logic [LINE_W-1:0]              ret_buf;   // line from the last memory transfer
    logic [LINE_W-1:0]              line_sel;
    logic [icache_pkg::FETCH_W-1:0] dw_data;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ret_buf <= '0;
        end else if (i_mem_ready) begin
            ret_buf <= i_mem_rdata;
        end
    end

    // refill answers from the buffer, lookup from the hit way
    assign line_sel = (i_state == icache_pkg::ST_REFILL) ? ret_buf
                    : (i_hit_way ? i_line1 : i_line0);

    assign dw_data = line_sel[i_dw_sel*icache_pkg::FETCH_W +: icache_pkg::FETCH_W];

    // uncached request is 8-byte aligned, data sits in the low doubleword
    assign o_resp_data = i_uncached ? ret_buf[icache_pkg::FETCH_W-1:0] : dw_data;

endmodule

/* rtl/icache_top.sv */
`timescale 1ns/1ps

module icache_top #(
    parameter int INDEX_W = 6,
    parameter int OFFS_W  = 2    // 32-bit words per line, log2
) (
    input  logic                              clk,
    input  logic                              rstn,
    // fetch request
    input  logic                              i_req_valid,
    output logic                              o_req_ready,
    input  logic [icache_pkg::ADDR_W-1:0]     i_req_addr,
    input  logic                              i_uncached,
    input  logic                              i_cacop_en,
    input  logic [icache_pkg::CACOP_W-1:0]    i_cacop_code,
    // fetch response
    output logic                              o_resp_valid,
    output logic [icache_pkg::FETCH_W-1:0]    o_resp_data,
    output logic [icache_pkg::ADDR_W-1:0]     o_resp_pc,
    output logic [icache_pkg::EXC_W-1:0]      o_resp_exc,
    output logic                              o_cacop_done,
    // memory side, whole line per transfer
    output logic                              o_mem_valid,
    input  logic                              i_mem_ready,
    output logic [icache_pkg::ADDR_W-1:0]     o_mem_addr,
    output logic                              o_mem_uncached,
    input  logic [(32 << OFFS_W)-1:0]         i_mem_rdata
);

    localparam int BOFF_W = OFFS_W + 2;
    localparam int TAG_W  = icache_pkg::ADDR_W - INDEX_W - BOFF_W;
    localparam int LINE_W = 32 << OFFS_W;

    logic [INDEX_W-1:0]            index;
    logic [TAG_W-1:0]              tag;
    logic [OFFS_W-2:0]             dw_sel;
    logic                          way_bit;
    logic                          uncached;
    logic                          index_inv;
    logic                          hit_inv;
    logic [icache_pkg::ST_W-1:0]   state;
    logic                          capture;
    logic                          hit;
    logic                          hit_way;
    logic [LINE_W-1:0]             line0;
    logic [LINE_W-1:0]             line1;
    logic                          fill_we;
    logic                          lru_we;
    logic                          inv_we;

    icache_req_decode #(.INDEX_W(INDEX_W), .OFFS_W(OFFS_W)) req_decode_i (
        .clk(clk), .rstn(rstn), .i_capture(capture),
        .i_req_addr(i_req_addr), .i_uncached(i_uncached),
        .i_cacop_en(i_cacop_en), .i_cacop_code(i_cacop_code),
        .o_index(index), .o_tag(tag), .o_dw_sel(dw_sel), .o_way_bit(way_bit),
        .o_uncached(uncached), .o_index_inv(index_inv), .o_hit_inv(hit_inv),
        .o_exc(o_resp_exc), .o_pc(o_resp_pc),
        .o_mem_addr(o_mem_addr), .o_mem_uncached(o_mem_uncached)
    );

    icache_ctrl ctrl_i (
        .clk(clk), .rstn(rstn),
        .i_req_valid(i_req_valid), .i_cacop_en(i_cacop_en),
        .o_req_ready(o_req_ready), .o_capture(capture),
        .i_hit(hit), .i_uncached(uncached),
        .i_index_inv(index_inv), .i_hit_inv(hit_inv), .i_exc(o_resp_exc),
        .o_state(state), .o_mem_valid(o_mem_valid), .i_mem_ready(i_mem_ready),
        .o_fill_we(fill_we), .o_lru_we(lru_we), .o_inv_we(inv_we),
        .o_resp_valid(o_resp_valid), .o_cacop_done(o_cacop_done)
    );

    icache_way_store #(.INDEX_W(INDEX_W), .OFFS_W(OFFS_W)) way_store_i (
        .clk(clk), .rstn(rstn),
        .i_rd_index(i_req_addr[INDEX_W+BOFF_W-1:BOFF_W]),   // raw request index
        .i_index(index), .i_tag(tag), .i_way_bit(way_bit), .i_index_inv(index_inv),
        .i_fill_we(fill_we), .i_lru_we(lru_we), .i_inv_we(inv_we),
        .i_fill_line(i_mem_rdata),
        .o_hit(hit), .o_hit_way(hit_way), .o_line0(line0), .o_line1(line1)
    );

    icache_fetch_result #(.OFFS_W(OFFS_W)) fetch_result_i (
        .clk(clk), .rstn(rstn), .i_state(state),
        .i_mem_ready(i_mem_ready), .i_mem_rdata(i_mem_rdata),
        .i_line0(line0), .i_line1(line1), .i_hit_way(hit_way),
        .i_dw_sel(dw_sel), .i_uncached(uncached),
        .o_resp_data(o_resp_data)
    );

endmodule

/* dv/icache_checker.sv */
`timescale 1ns/1ps

module icache_checker #(
    parameter int INDEX_W = 4,
    parameter int OFFS_W  = 2
) (
    input  logic        clk,
    input  logic        rstn,
    input  logic        i_req_valid,
    input  logic        i_req_ready,
    input  logic [31:0] i_req_addr,
    input  logic        i_uncached,
    input  logic        i_cacop_en,
    input  logic [1:0]  i_cacop_code,
    input  logic        i_exp_miss,      // pattern flag that travels with the request
    input  logic        i_resp_valid,
    input  logic [63:0] i_resp_data,
    input  logic [31:0] i_resp_pc,
    input  logic [6:0]  i_resp_exc,
    input  logic        i_cacop_done,
    input  logic        i_mem_valid,
    input  logic        i_mem_ready,
    input  logic [31:0] i_mem_addr,
    input  logic        i_mem_uncached,
    output int          o_err_cnt,
    output int          o_done_cnt
);

    localparam int BOFF_W = OFFS_W + 2;
    localparam int SETS   = 1 << INDEX_W;

    logic [31:0] tag_m   [2][SETS];   // address bits above the index
    logic        valid_m [2][SETS];
    logic        lru_m   [SETS];      // 1 when way 1 goes next
    int          cycle;
    int          pat_n;
    logic        busy;                // one request in flight
    logic [31:0] cur_addr;
    logic        cur_cacop;
    logic        cur_unc;
    logic        cur_exc;
    logic        cur_mem;             // memory transfer expected
    int          cur_start;
    int          mem_cnt;
    int          mem_cycle;
    int          cur_errs;

    task automatic note_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        cur_errs++;
        o_err_cnt++;
    endtask

    task automatic raise_error(input string msg);
        $display("error at %0t: %s", $time, msg);
        cur_errs++;
        o_err_cnt++;
    endtask

    // two-way lookup, LRU fill and invalidates on the model
    task automatic model_request();
        int                 hw;
        logic [INDEX_W-1:0] idx;
        logic [31:0]        tg;
        logic               v;
        idx = i_req_addr[BOFF_W +: INDEX_W];
        tg  = i_req_addr >> (INDEX_W + BOFF_W);
        hw  = -1;
        for (int w = 0; w < 2; w++) begin
            if (valid_m[w][idx] && tag_m[w][idx] == tg) hw = w;
        end
        cur_mem = 1'b0;
        if (cur_cacop) begin
            if (i_cacop_code == icache_pkg::CACOP_INDEX_INV) valid_m[i_req_addr[0]][idx] = 1'b0;
            else if (hw >= 0) valid_m[hw][idx] = 1'b0;
        end else if (!cur_exc && cur_unc) begin
            cur_mem = 1'b1;   // bypass without allocation
        end else if (!cur_exc && hw >= 0) begin
            lru_m[idx] = (hw == 0);
        end else if (!cur_exc) begin
            v               = lru_m[idx];
            valid_m[v][idx] = 1'b1;
            tag_m[v][idx]   = tg;
            lru_m[idx]      = !v;
            cur_mem         = 1'b1;
        end
    endtask

    always @(posedge clk) begin
        logic [31:0] a8;
        logic [31:0] mem_exp;
        logic [63:0] data_exp;
        logic [6:0]  exc_exp;
        if (!rstn) begin
            busy  = 1'b0;
            cycle = 0;
            for (int s = 0; s < SETS; s++) begin
                valid_m[0][s] = 1'b0;
                valid_m[1][s] = 1'b0;
                lru_m[s]      = 1'b0;
            end
        end else begin
            cycle++;
            a8       = {cur_addr[31:3], 3'b000};
            mem_exp  = cur_unc ? a8 : (cur_addr >> BOFF_W) << BOFF_W;
            // word at A holds A ^ c0de0000
            data_exp = {(a8 + 32'd4) ^ 32'hc0de0000, a8 ^ 32'hc0de0000};
            exc_exp  = cur_exc ? icache_pkg::EXC_ADEF : icache_pkg::EXC_NONE;
            if (i_mem_valid && i_mem_ready) begin
                if (!busy || !cur_mem) begin
                    raise_error($sformatf("memory request to %h that no miss called for",
                                          i_mem_addr));
                end else begin
                    if (i_mem_addr !== mem_exp) note_mismatch("o_mem_addr", i_mem_addr, mem_exp);
                    if (i_mem_uncached !== cur_unc) begin
                        note_mismatch("o_mem_uncached", i_mem_uncached, cur_unc);
                    end
                end
                mem_cnt++;
                mem_cycle = cycle;
            end
            if (i_resp_valid || i_cacop_done) begin
                if (!busy) begin
                    raise_error("response came with no request in flight");
                end else begin
                    if (i_cacop_done != cur_cacop) raise_error("wrong kind of completion");
                    if (cur_mem && cycle != mem_cycle + 1) begin
                        raise_error("response not in the cycle after the memory transfer");
                    end
                    if (!cur_mem && cycle - cur_start != (cur_cacop ? 2 : 1)) begin
                        raise_error($sformatf("completion %0d cycles after acceptance",
                                              cycle - cur_start));
                    end
                    if (mem_cnt != int'(cur_mem)) begin
                        raise_error($sformatf("%0d memory requests where %0d were due",
                                              mem_cnt, cur_mem));
                    end
                    // a hit keeps the request side open while it answers
                    if (!cur_cacop && !cur_exc && !cur_mem && !i_req_ready) begin
                        raise_error("o_req_ready low in the cycle that answers a hit");
                    end
                    if (!cur_cacop) begin
                        if (i_resp_pc !== cur_addr) begin
                            note_mismatch("o_resp_pc", i_resp_pc, cur_addr);
                        end
                        if (i_resp_exc !== exc_exp) begin
                            note_mismatch("o_resp_exc", i_resp_exc, exc_exp);
                        end
                        if (!cur_exc && i_resp_data !== data_exp) begin
                            note_mismatch("o_resp_data", i_resp_data, data_exp);
                        end
                    end
                    $display("pattern %0d addr %h %s", pat_n, cur_addr,
                             cur_errs == 0 ? "ok" : "failed");
                    pat_n++;
                    o_done_cnt++;
                    busy = 1'b0;
                end
            end
            if (i_req_valid && i_req_ready) begin
                cur_addr  = i_req_addr;
                cur_cacop = i_cacop_en;
                cur_unc   = i_uncached;
                cur_exc   = !i_cacop_en && (i_req_addr[1:0] != 2'b00);
                cur_start = cycle;
                mem_cnt   = 0;
                cur_errs  = 0;
                busy      = 1'b1;
                model_request();
                if (i_exp_miss != cur_mem) begin
                    raise_error("pattern miss flag disagrees with the model");
                end
            end
        end
    end

endmodule

/* dv/tb_icache.sv */
`timescale 1ns/1ps

module tb_icache;

    localparam int INDEX_W = 4;
    localparam int OFFS_W  = 2;
    localparam int LINE_W  = 32 << OFFS_W;
    localparam int MAX_PAT = 64;
    localparam int TIMEOUT = 100;   // cycles allowed per wait

    logic              clk;
    logic              rstn;
    logic              req_valid;
    logic [31:0]       req_addr;
    logic              uncached;
    logic              cacop_en;
    logic [1:0]        cacop_code;
    logic              exp_miss;
    logic              mem_ready = 1'b0;
    logic [LINE_W-1:0] mem_rdata = '0;
    logic              req_ready;
    logic              resp_valid;
    logic [63:0]       resp_data;
    logic [31:0]       resp_pc;
    logic [6:0]        resp_exc;
    logic              cacop_done;
    logic              mem_valid;
    logic [31:0]       mem_addr;
    logic              mem_uncached;
    logic [31:0]       pat_mem [4*MAX_PAT];   // op, miss, chain, address
    logic [31:0]       lfsr = 32'h63ed0a3c;
    logic [2:0]        mem_wait;
    logic              mem_busy;
    int                npat;
    int                err_cnt;
    int                done_cnt;

    icache_top #(.INDEX_W(INDEX_W), .OFFS_W(OFFS_W)) icache_top_i (
        .clk(clk), .rstn(rstn), .i_req_valid(req_valid), .o_req_ready(req_ready),
        .i_req_addr(req_addr), .i_uncached(uncached), .i_cacop_en(cacop_en),
        .i_cacop_code(cacop_code), .o_resp_valid(resp_valid), .o_resp_data(resp_data),
        .o_resp_pc(resp_pc), .o_resp_exc(resp_exc), .o_cacop_done(cacop_done),
        .o_mem_valid(mem_valid), .i_mem_ready(mem_ready), .o_mem_addr(mem_addr),
        .o_mem_uncached(mem_uncached), .i_mem_rdata(mem_rdata)
    );

    icache_checker #(.INDEX_W(INDEX_W), .OFFS_W(OFFS_W)) icache_checker_i (
        .clk(clk), .rstn(rstn), .i_req_valid(req_valid), .i_req_ready(req_ready),
        .i_req_addr(req_addr), .i_uncached(uncached), .i_cacop_en(cacop_en),
        .i_cacop_code(cacop_code), .i_exp_miss(exp_miss), .i_resp_valid(resp_valid),
        .i_resp_data(resp_data), .i_resp_pc(resp_pc), .i_resp_exc(resp_exc),
        .i_cacop_done(cacop_done), .i_mem_valid(mem_valid), .i_mem_ready(mem_ready),
        .i_mem_addr(mem_addr), .i_mem_uncached(mem_uncached),
        .o_err_cnt(err_cnt), .o_done_cnt(done_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // memory answers each request after 0 to 7 cycles
    always @(posedge clk) begin
        if (!rstn || mem_ready) begin
            mem_ready <= 1'b0;
            mem_busy = 1'b0;
        end else if (mem_valid) begin
            if (!mem_busy) begin
                mem_busy = 1'b1;
                for (int b = 0; b < 3; b++) begin
                    lfsr     = lfsr_next(lfsr);
                    mem_wait = {mem_wait[1:0], lfsr[0]};
                end
            end
            if (mem_wait == 3'd0) begin
                mem_ready <= 1'b1;
                for (int k = 0; k < (1 << OFFS_W); k++) begin
                    mem_rdata[32*k +: 32] <= (mem_addr + 32'(4 * k)) ^ 32'hc0de0000;
                end
            end else begin
                mem_wait = mem_wait - 3'd1;
            end
        end
    end

    task automatic drive_req(input int n);
        logic [3:0] op;
        op = pat_mem[4*n][3:0];
        req_valid  <= 1'b1;
        req_addr   <= pat_mem[4*n+3];
        uncached   <= (op == 4'd2);
        cacop_en   <= (op >= 4'd3);
        cacop_code <= (op == 4'd3) ? icache_pkg::CACOP_INDEX_INV : icache_pkg::CACOP_HIT_INV;
        exp_miss   <= pat_mem[4*n+1][0];
    endtask

    task automatic wait_accept(output logic ok);
        int cnt;
        ok  = 1'b0;
        cnt = 0;
        while (!ok && cnt < TIMEOUT) begin
            @(posedge clk);
            ok  = req_ready;
            cnt = cnt + 1;
        end
        if (!ok) $display("timeout at %0t: request to %h was never accepted", $time, req_addr);
    endtask

    task automatic wait_done(output logic ok);
        int cnt;
        ok  = 1'b0;
        cnt = 0;
        while (!ok && cnt < TIMEOUT) begin
            @(posedge clk);
            ok  = resp_valid || cacop_done;
            cnt = cnt + 1;
        end
        if (!ok) $display("timeout at %0t: no response for request to %h", $time, req_addr);
    endtask

    initial begin
        logic ok;
        int   n;
        rstn       = 1'b0;
        req_valid  = 1'b0;
        req_addr   = '0;
        uncached   = 1'b0;
        cacop_en   = 1'b0;
        cacop_code = '0;
        exp_miss   = 1'b0;
        for (int i = 0; i < 4 * MAX_PAT; i++) begin
            pat_mem[i] = '0;
        end
        $readmemh("dv/icache_patterns.hex", pat_mem);
        npat = 0;
        while (npat < MAX_PAT && pat_mem[4*npat] != 0) npat++;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);
        if (npat > 0) drive_req(0);
        ok = 1'b1;
        for (n = 0; n < npat && ok; n++) begin
            wait_accept(ok);
            if (ok && n + 1 < npat && pat_mem[4*(n+1)+2][0]) begin
                drive_req(n + 1);   // back to back
            end else if (ok) begin
                req_valid <= 1'b0;
                wait_done(ok);
                if (ok && n + 1 < npat) drive_req(n + 1);
            end
        end
        @(posedge clk);
        $display("patterns %0d, completed %0d, errors %0d", npat, done_cnt, err_cnt);
        if (ok && npat > 0 && err_cnt == 0 && done_cnt == npat) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
rtl/icache_pkg.sv
rtl/icache_req_decode.sv
rtl/icache_ctrl.sv
rtl/icache_way_store.sv
rtl/icache_fetch_result.sv
rtl/icache_top.sv
dv/icache_checker.sv
dv/tb_icache.sv

/* dv/icache_patterns.hex */
// columns: op, expected miss, issued right behind the previous one, address
// op 1 fetch, 2 uncached fetch, 3 index invalidate, 4 hit invalidate
1 1 0 00001000
1 0 0 00001008
1 0 0 00001004
1 0 1 0000100c
1 0 1 00001000
// three tags in set 2
1 1 0 00002020
1 1 0 00003020
1 0 0 00002028
1 1 0 00004020
1 0 0 00002028
1 1 0 00003024
// uncached, then the same line cached
2 1 0 0000500c
1 1 0 00005008
// misaligned
1 0 0 00001002
1 0 0 00001001
// index invalidate of set 0 way 0, then hit invalidate in set 2
3 0 0 00000000
1 1 0 00001000
1 0 0 0000500c
4 0 0 00003020
1 1 0 00003020
4 0 0 00007020
1 0 0 00003028
